//--- list.f
rtl/ioctl_pkg.sv
rtl/ioctl_stream_if.sv
rtl/ioctl_capture.sv
rtl/ioctl_fifo.sv
rtl/ioctl_dispatch.sv
rtl/jt_ioctl_loader.sv
tb/tb_jt_ioctl_loader.sv

//--- rtl/ioctl_capture.sv
// Front stage of the download decoder.
// Takes loader writes, decodes the file index into a destination and
// drops writes that have no effect downstream. An accepted byte sits
// in a one-entry register until the FIFO takes it, which is what
// produces back-pressure on ioctl_ready.
// Also registers the downloading and ioctl_ram flags.

`timescale 1ns/1ps

module ioctl_capture (
    input  logic                clk_rom,
    input  logic                rst,
    input  logic                ioctl_download,
    input  logic                ioctl_wr,
    input  ioctl_pkg::index_t   ioctl_index,
    input  ioctl_pkg::addr_t    ioctl_addr,
    input  ioctl_pkg::data_t    ioctl_data,
    output logic                ioctl_ready,
    output logic                downloading,
    output logic                ioctl_ram,
    ioctl_stream_if.src         out
);

    logic             accept;
    logic             keep;        // Write survives the filters
    ioctl_pkg::dest_e dest_dec;

    // Slot is free when empty or draining this cycle
    assign ioctl_ready = !out.valid || out.ready;
    assign accept      = ioctl_wr && ioctl_ready;

    always_comb begin
        keep     = 1'b0;
        dest_dec = ioctl_pkg::DEST_ROM;
        case (ioctl_index)
            ioctl_pkg::IDX_ROM: begin
                keep     = 1'b1;
                dest_dec = ioctl_pkg::DEST_ROM;
            end
            ioctl_pkg::IDX_NVRAM: begin
                keep     = 1'b1;
                dest_dec = ioctl_pkg::DEST_NVRAM;
            end
            ioctl_pkg::IDX_DIPSW: begin
                // Only the first bytes map onto the DIP word
                keep     = ioctl_addr < ioctl_pkg::ADDR_W'(ioctl_pkg::DIPSW_BYTES);
                dest_dec = ioctl_pkg::DEST_DIP;
            end
            ioctl_pkg::IDX_MOD: begin
                keep     = !ioctl_addr[0];   // Odd bytes are ignored
                dest_dec = ioctl_pkg::DEST_MOD;
            end
            default: keep = 1'b0;            // Unknown file
        endcase
    end

    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else if (ioctl_ready) begin
            out.valid <= accept && keep;
        end
    end

    // Payload only loads when the slot refills
    always_ff @(posedge clk_rom) begin
        if (accept && keep) begin
            out.dest <= dest_dec;
            out.addr <= ioctl_addr;
            out.data <= ioctl_data;
        end
    end

    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            downloading <= 1'b0;
            ioctl_ram   <= 1'b0;
        end else begin
            downloading <= ioctl_download && ioctl_index == ioctl_pkg::IDX_ROM;
            ioctl_ram   <= ioctl_download && ioctl_index == ioctl_pkg::IDX_NVRAM;
        end
    end

    // A stalled byte must not change under the FIFO
    a_stall_stable: assert property (
        @(posedge clk_rom) disable iff (rst)
        out.valid && !out.ready |=> out.valid && $stable(out.dest)
            && $stable(out.addr) && $stable(out.data)
    );

endmodule

//--- rtl/ioctl_dispatch.sv
// Back stage of the download decoder.
// Pops classified bytes and routes them by destination.
// DIP bytes land in their lane of the DIP word and MOD bytes set the
// core configuration, both on the pop edge. ROM and NVRAM bytes load
// the ROM output register, a valid/ready port towards the memory
// writer. Nothing is popped while that register is stalled.

`timescale 1ns/1ps

module ioctl_dispatch (
    input  logic                  clk_rom,
    input  logic                  rst,
    ioctl_stream_if.dst           in,
    output logic                  rom_valid,
    output ioctl_pkg::addr_t      rom_addr,
    output ioctl_pkg::data_t      rom_data,
    output logic                  rom_nvram,
    input  logic                  rom_ready,
    output ioctl_pkg::core_mod_t  core_mod,
    output ioctl_pkg::dipsw_t     dipsw
);

    logic pop;
    logic to_rom;    // Item heads for the ROM port

    assign in.ready = !rom_valid || rom_ready;
    assign pop      = in.valid && in.ready;
    assign to_rom   = in.dest == ioctl_pkg::DEST_ROM || in.dest == ioctl_pkg::DEST_NVRAM;

    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            rom_valid <= 1'b0;
        end else if (in.ready) begin
            rom_valid <= pop && to_rom;
        end
    end

    always_ff @(posedge clk_rom) begin
        if (pop && to_rom) begin
            rom_addr  <= in.addr;
            rom_data  <= in.data;
            rom_nvram <= in.dest == ioctl_pkg::DEST_NVRAM;
        end
    end

    // Configuration registers
    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            core_mod <= ioctl_pkg::CORE_MOD_RESET;
            dipsw    <= ioctl_pkg::DIPSW_RESET;
        end else if (pop) begin
            case (in.dest)
                ioctl_pkg::DEST_DIP: begin
                    dipsw[{in.addr[1:0], 3'b000} +: 8] <= in.data;  // Byte lane
                end
                ioctl_pkg::DEST_MOD: begin
                    core_mod <= in.data[ioctl_pkg::MOD_W-1:0];
                end
                default: begin
                    // ROM and NVRAM handled above
                end
            endcase
        end
    end

    // Memory writer must see each byte until it takes it
    a_rom_hold: assert property (
        @(posedge clk_rom) disable iff (rst)
        rom_valid && !rom_ready |=> rom_valid && $stable(rom_addr)
            && $stable(rom_data) && $stable(rom_nvram)
    );

endmodule

//--- rtl/ioctl_fifo.sv
// Elastic buffer between capture and dispatch.
// Circular buffer with read and write pointers and a fill count.
// Output valid comes from the count only, so a pushed item shows up
// one edge later at the earliest. Input ready drops only when full.
// A pop in the same cycle does not open a slot.
// FIFO_DEPTH must be a power of two so the pointers wrap naturally.

`timescale 1ns/1ps

module ioctl_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic         clk_rom,
    input  logic         rst,
    ioctl_stream_if.dst  in,
    ioctl_stream_if.src  out
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    ioctl_pkg::dest_e dest_mem [FIFO_DEPTH];
    ioctl_pkg::addr_t addr_mem [FIFO_DEPTH];
    ioctl_pkg::data_t data_mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    assign full      = count == CNT_W'(FIFO_DEPTH);
    assign in.ready  = !full;
    assign out.valid = count != '0;
    assign push      = in.valid && in.ready;
    assign pop       = out.valid && out.ready;

    // Head of the queue straight from storage
    assign out.dest = dest_mem[rd_ptr];
    assign out.addr = addr_mem[rd_ptr];
    assign out.data = data_mem[rd_ptr];

    always_ff @(posedge clk_rom) begin
        if (push) begin
            dest_mem[wr_ptr] <= in.dest;
            addr_mem[wr_ptr] <= in.addr;
            data_mem[wr_ptr] <= in.data;
        end
    end

    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Fill count never runs past the storage or wraps below zero
    a_count_range: assert property (
        @(posedge clk_rom) disable iff (rst)
        count <= CNT_W'(FIFO_DEPTH)
    );

    // Write pointer leads the read pointer by exactly the fill count
    a_ptr_count: assert property (
        @(posedge clk_rom) disable iff (rst)
        PTR_W'(wr_ptr - rd_ptr) == PTR_W'(count)
    );

endmodule

//--- rtl/ioctl_pkg.sv
// Shared definitions for the download stream decoder.
// Holds the loader's file index codes, the payload widths and types,
// the destination codes used on the internal stream and the values
// that the configuration registers take after reset.
// RTL and testbench refer to these by scoped names.

package ioctl_pkg;

    // Payload widths
    localparam int INDEX_W     = 8;
    localparam int ADDR_W      = 25;
    localparam int DATA_W      = 8;
    localparam int MOD_W       = 7;
    localparam int DIPSW_BYTES = 4;   // DIP word is filled one byte per write

    typedef logic [INDEX_W-1:0]       index_t;
    typedef logic [ADDR_W-1:0]        addr_t;
    typedef logic [DATA_W-1:0]        data_t;
    typedef logic [MOD_W-1:0]         core_mod_t;
    typedef logic [DIPSW_BYTES*8-1:0] dipsw_t;

    // File index codes sent by the loader
    localparam index_t IDX_ROM   = 8'd0;
    localparam index_t IDX_MOD   = 8'd1;
    localparam index_t IDX_NVRAM = 8'd2;
    localparam index_t IDX_DIPSW = 8'd254;

    // Where a classified byte ends up
    typedef enum logic [1:0] {
        DEST_ROM   = 2'd0,
        DEST_NVRAM = 2'd1,
        DEST_DIP   = 2'd2,
        DEST_MOD   = 2'd3
    } dest_e;

    // Bit 0 set selects the default horizontal layout
    localparam core_mod_t CORE_MOD_RESET = 7'd1;

    // All switches off until the DIP file arrives
    localparam dipsw_t DIPSW_RESET = '1;

endpackage

//--- rtl/ioctl_stream_if.sv
// One classified download byte moving between pipeline stages.
// Valid/ready handshake: a transfer happens on an edge with both high.
// Once valid rises, valid and payload hold until the transfer.
// The source stage connects through src, the sink through dst.

`timescale 1ns/1ps

interface ioctl_stream_if;

    logic              valid;
    logic              ready;
    ioctl_pkg::dest_e  dest;
    ioctl_pkg::addr_t  addr;
    ioctl_pkg::data_t  data;

    modport src (
        output valid,
        output dest,
        output addr,
        output data,
        input  ready
    );

    modport dst (
        input  valid,
        input  dest,
        input  addr,
        input  data,
        output ready
    );

endinterface

//--- rtl/jt_ioctl_loader.sv
// Download stream decoder, top level.
// Loader writes enter through ioctl_* with ioctl_ready as back-pressure.
// ROM and NVRAM bytes leave through the rom_* valid/ready port, DIP and
// module-config bytes update dipsw and core_mod.
// Pipeline is capture, FIFO, dispatch; minimum latency from accept to
// rom_valid is three cycles.

`timescale 1ns/1ps

module jt_ioctl_loader #(
    parameter int FIFO_DEPTH = 4   // Power of two
) (
    input  logic                  clk_rom,
    input  logic                  rst,

    // Loader side
    input  logic                  ioctl_download,
    input  ioctl_pkg::index_t     ioctl_index,
    input  logic                  ioctl_wr,
    input  ioctl_pkg::addr_t      ioctl_addr,
    input  ioctl_pkg::data_t      ioctl_data,
    output logic                  ioctl_ready,

    // ROM write port
    output logic                  rom_valid,
    output ioctl_pkg::addr_t      rom_addr,
    output ioctl_pkg::data_t      rom_data,
    output logic                  rom_nvram,
    input  logic                  rom_ready,

    // Configuration and status
    output ioctl_pkg::core_mod_t  core_mod,
    output ioctl_pkg::dipsw_t     dipsw,
    output logic                  downloading,
    output logic                  ioctl_ram
);

    ioctl_stream_if cap_to_buf ();
    ioctl_stream_if buf_to_disp ();

    ioctl_capture u_capture (
        .clk_rom        ( clk_rom           ),
        .rst            ( rst               ),
        .ioctl_download ( ioctl_download    ),
        .ioctl_wr       ( ioctl_wr          ),
        .ioctl_index    ( ioctl_index       ),
        .ioctl_addr     ( ioctl_addr        ),
        .ioctl_data     ( ioctl_data        ),
        .ioctl_ready    ( ioctl_ready       ),
        .downloading    ( downloading       ),
        .ioctl_ram      ( ioctl_ram         ),
        .out            ( cap_to_buf.src    )
    );

    ioctl_fifo #(
        .FIFO_DEPTH     ( FIFO_DEPTH        )
    ) u_fifo (
        .clk_rom        ( clk_rom           ),
        .rst            ( rst               ),
        .in             ( cap_to_buf.dst    ),
        .out            ( buf_to_disp.src   )
    );

    ioctl_dispatch u_dispatch (
        .clk_rom        ( clk_rom           ),
        .rst            ( rst               ),
        .in             ( buf_to_disp.dst   ),
        .rom_valid      ( rom_valid         ),
        .rom_addr       ( rom_addr          ),
        .rom_data       ( rom_data          ),
        .rom_nvram      ( rom_nvram         ),
        .rom_ready      ( rom_ready         ),
        .core_mod       ( core_mod          ),
        .dipsw          ( dipsw             )
    );

endmodule

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_jt_ioctl_loader \
    -Mdir obj_dir -o sim_tb \
    -f list.f

./obj_dir/sim_tb | tee sim.log

if grep -q "TEST PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- tb/tb_jt_ioctl_loader.sv
// Testbench for the download stream decoder.
// Applies a table of loader writes, drives rom_ready from an LFSR with
// one forced long stall, and checks the ROM port against a queue of
// expected writes. DIP and module-config results are checked against
// model registers after the pipeline drains. Download flags are checked
// every cycle, one cycle after the inputs that set them.

`timescale 1ns/1ps

module tb_jt_ioctl_loader;

    localparam int FIFO_DEPTH = 4;
    localparam int STALL_LEN  = 40;   // Long enough to fill every stage

    typedef enum {EXP_ROM, EXP_NVRAM, EXP_DIP, EXP_MOD, EXP_DROP} exp_e;

    logic                 clk_rom;
    logic                 rst;
    logic                 ioctl_download;
    ioctl_pkg::index_t    ioctl_index;
    logic                 ioctl_wr;
    ioctl_pkg::addr_t     ioctl_addr;
    ioctl_pkg::data_t     ioctl_data;
    logic                 ioctl_ready;
    logic                 rom_valid;
    ioctl_pkg::addr_t     rom_addr;
    ioctl_pkg::data_t     rom_data;
    logic                 rom_nvram;
    logic                 rom_ready;
    ioctl_pkg::core_mod_t core_mod;
    ioctl_pkg::dipsw_t    dipsw;
    logic                 downloading;
    logic                 ioctl_ram;

    // Stimulus table
    string             tab_name  [$];
    logic              tab_dl    [$];
    ioctl_pkg::index_t tab_idx   [$];
    ioctl_pkg::addr_t  tab_addr  [$];
    ioctl_pkg::data_t  tab_data  [$];
    exp_e              tab_exp   [$];
    logic              tab_stall [$];

    // Expected ROM port writes in arrival order
    string             exp_rom_name [$];
    ioctl_pkg::addr_t  exp_rom_addr [$];
    ioctl_pkg::data_t  exp_rom_data [$];
    logic              exp_rom_nv   [$];

    ioctl_pkg::core_mod_t model_mod;
    ioctl_pkg::dipsw_t    model_dipsw;

    string            cur_name = "reset";
    int               stall_left = 0;
    logic [15:0]      lfsr_state = 16'd38469;
    int               cycles = 0;
    int               cycle_limit = 0;
    logic             saw_ready_low = 1'b0;
    logic             held = 1'b0;        // ROM port stalled at last sample
    ioctl_pkg::addr_t held_addr;
    ioctl_pkg::data_t held_data;
    logic             held_nv;
    logic             exp_dl = 1'b0;
    logic             exp_ram = 1'b0;

    jt_ioctl_loader #(
        .FIFO_DEPTH     ( FIFO_DEPTH     )
    ) u_jt_ioctl_loader (
        .clk_rom        ( clk_rom        ),
        .rst            ( rst            ),
        .ioctl_download ( ioctl_download ),
        .ioctl_index    ( ioctl_index    ),
        .ioctl_wr       ( ioctl_wr       ),
        .ioctl_addr     ( ioctl_addr     ),
        .ioctl_data     ( ioctl_data     ),
        .ioctl_ready    ( ioctl_ready    ),
        .rom_valid      ( rom_valid      ),
        .rom_addr       ( rom_addr       ),
        .rom_data       ( rom_data       ),
        .rom_nvram      ( rom_nvram      ),
        .rom_ready      ( rom_ready      ),
        .core_mod       ( core_mod       ),
        .dipsw          ( dipsw          ),
        .downloading    ( downloading    ),
        .ioctl_ram      ( ioctl_ram      )
    );

    initial begin
        clk_rom = 1'b0;
        forever #5 clk_rom = ~clk_rom;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], fb};
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_rom(input string name,
                             input ioctl_pkg::addr_t exp_addr, input ioctl_pkg::data_t exp_data,
                             input logic exp_nv, input ioctl_pkg::addr_t act_addr,
                             input ioctl_pkg::data_t act_data, input logic act_nv);
        if (act_addr !== exp_addr || act_data !== exp_data || act_nv !== exp_nv) begin
            $display("Mismatch %s: expected addr %h data %h nv %b, actual addr %h data %h nv %b",
                     name, exp_addr, exp_data, exp_nv, act_addr, act_data, act_nv);
            report_failure("ROM port write is wrong");
        end
    endtask

    task automatic check_mod(input string name, input ioctl_pkg::core_mod_t exp_val,
                             input ioctl_pkg::core_mod_t act_val);
        if (act_val !== exp_val) begin
            $display("Mismatch %s: expected core_mod %h, actual %h", name, exp_val, act_val);
            report_failure("core_mod is wrong");
        end
    endtask

    task automatic check_dipsw(input string name, input ioctl_pkg::dipsw_t exp_val,
                               input ioctl_pkg::dipsw_t act_val);
        if (act_val !== exp_val) begin
            $display("Mismatch %s: expected dipsw %h, actual %h", name, exp_val, act_val);
            report_failure("dipsw is wrong");
        end
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("Mismatch %s: expected %b, actual %b", name, exp_val, act_val);
            report_failure("Status flag is wrong");
        end
    endtask

    task automatic add_entry(input string name, input logic dl, input ioctl_pkg::index_t idx,
                             input ioctl_pkg::addr_t addr, input ioctl_pkg::data_t data,
                             input exp_e exp, input logic stall);
        tab_name.push_back(name);
        tab_dl.push_back(dl);
        tab_idx.push_back(idx);
        tab_addr.push_back(addr);
        tab_data.push_back(data);
        tab_exp.push_back(exp);
        tab_stall.push_back(stall);
    endtask

    task automatic build_table();
        add_entry("rom_0",       1'b1, ioctl_pkg::IDX_ROM,   25'h0000000, 8'h3c, EXP_ROM,   1'b0);
        add_entry("rom_1",       1'b1, ioctl_pkg::IDX_ROM,   25'h0000001, 8'ha5, EXP_ROM,   1'b0);
        add_entry("rom_top",     1'b1, ioctl_pkg::IDX_ROM,   25'h1ffffff, 8'h5a, EXP_ROM,   1'b0);
        add_entry("nvram_0",     1'b1, ioctl_pkg::IDX_NVRAM, 25'h0000010, 8'h77, EXP_NVRAM, 1'b0);
        add_entry("nvram_1",     1'b0, ioctl_pkg::IDX_NVRAM, 25'h0000011, 8'h88, EXP_NVRAM, 1'b0);
        add_entry("dip_lane0",   1'b1, ioctl_pkg::IDX_DIPSW, 25'h0000000, 8'h12, EXP_DIP,   1'b0);
        add_entry("dip_lane1",   1'b1, ioctl_pkg::IDX_DIPSW, 25'h0000001, 8'h34, EXP_DIP,   1'b0);
        add_entry("dip_lane2",   1'b0, ioctl_pkg::IDX_DIPSW, 25'h0000002, 8'h56, EXP_DIP,   1'b0);
        add_entry("dip_lane3",   1'b0, ioctl_pkg::IDX_DIPSW, 25'h0000003, 8'h78, EXP_DIP,   1'b0);
        add_entry("dip_addr4",   1'b1, ioctl_pkg::IDX_DIPSW, 25'h0000004, 8'h00, EXP_DROP,  1'b0);
        add_entry("dip_addr9",   1'b1, ioctl_pkg::IDX_DIPSW, 25'h0000009, 8'hff, EXP_DROP,  1'b0);
        add_entry("mod_even0",   1'b1, ioctl_pkg::IDX_MOD,   25'h0000000, 8'hff, EXP_MOD,   1'b0);
        add_entry("mod_odd1",    1'b1, ioctl_pkg::IDX_MOD,   25'h0000001, 8'h00, EXP_DROP,  1'b0);
        add_entry("mod_even2",   1'b1, ioctl_pkg::IDX_MOD,   25'h0000002, 8'h82, EXP_MOD,   1'b0);
        add_entry("unknown_3",   1'b1, 8'd3,                 25'h0000000, 8'h11, EXP_DROP,  1'b0);
        add_entry("unknown_255", 1'b1, 8'd255,               25'h0000000, 8'h22, EXP_DROP,  1'b0);
        for (int k = 0; k < 8; k++) begin
            // First burst write starts the long stall
            add_entry($sformatf("burst_%0d", k), 1'b1, ioctl_pkg::IDX_ROM,
                      ioctl_pkg::addr_t'(32'h100 + k), ioctl_pkg::data_t'(32'hc0 + k * 3),
                      EXP_ROM, k == 0);
        end
        add_entry("nvram_tail",  1'b1, ioctl_pkg::IDX_NVRAM, 25'h0000020, 8'hc3, EXP_NVRAM, 1'b0);
        add_entry("rom_no_dl",   1'b0, ioctl_pkg::IDX_ROM,   25'h0000200, 8'h99, EXP_ROM,   1'b0);
    endtask

    // Holds one write until the DUT accepts it, then updates the model
    task automatic apply_entry(input int i);
        logic             taken;
        ioctl_pkg::addr_t a;
        ioctl_pkg::data_t d;
        int               lane;
        a = tab_addr[i];
        d = tab_data[i];
        cur_name = tab_name[i];
        ioctl_download <= tab_dl[i];
        ioctl_index    <= tab_idx[i];
        ioctl_addr     <= a;
        ioctl_data     <= d;
        ioctl_wr       <= 1'b1;
        if (tab_stall[i]) stall_left <= STALL_LEN;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk_rom);
            taken = ioctl_ready;   // Stable until the next edge
            @(posedge clk_rom);
        end
        case (tab_exp[i])
            EXP_ROM, EXP_NVRAM: begin
                exp_rom_name.push_back(tab_name[i]);
                exp_rom_addr.push_back(a);
                exp_rom_data.push_back(d);
                exp_rom_nv.push_back(tab_exp[i] == EXP_NVRAM);
            end
            EXP_DIP: begin
                lane = int'(a[1:0]);
                model_dipsw[lane * 8 +: 8] = d;
            end
            EXP_MOD: model_mod = d[6:0];
            default: begin
            end
        endcase
    endtask

    // Waits until every accepted byte has left the pipeline
    task automatic drain_pipeline();
        ioctl_wr <= 1'b0;
        @(negedge clk_rom);
        while (exp_rom_addr.size() != 0 || rom_valid) @(negedge clk_rom);
        repeat (4) @(negedge clk_rom);   // Capture, FIFO and dispatch stages
    endtask

    always @(posedge clk_rom) begin
        if (stall_left > 0) begin
            rom_ready  <= 1'b0;
            stall_left <= stall_left - 1;
        end else begin
            lfsr_state = lfsr_step(lfsr_state);
            rom_ready <= lfsr_state[0];
        end
    end

    always @(posedge clk_rom) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            report_failure($sformatf("Timeout after %0d cycles, the download did not finish",
                                     cycles));
        end
    end

    // ROM port monitor sampled mid-cycle
    always @(negedge clk_rom) begin
        if (!rst) begin
            if (!ioctl_ready) saw_ready_low = 1'b1;
            if (held) begin
                if (!rom_valid) begin
                    report_failure("rom_valid dropped before the write was accepted");
                end else begin
                    check_rom((exp_rom_name.size() != 0) ? exp_rom_name[0] : cur_name,
                              held_addr, held_data, held_nv, rom_addr, rom_data, rom_nvram);
                end
            end
            if (rom_valid && rom_ready) begin
                if (exp_rom_addr.size() == 0) begin
                    report_failure("ROM port wrote a byte that was not expected");
                end else begin
                    check_rom(exp_rom_name[0], exp_rom_addr[0], exp_rom_data[0], exp_rom_nv[0],
                              rom_addr, rom_data, rom_nvram);
                    void'(exp_rom_name.pop_front());
                    void'(exp_rom_addr.pop_front());
                    void'(exp_rom_data.pop_front());
                    void'(exp_rom_nv.pop_front());
                end
            end
            held      = rom_valid && !rom_ready;
            held_addr = rom_addr;
            held_data = rom_data;
            held_nv   = rom_nvram;
        end
    end

    // Flags follow the inputs seen one edge earlier
    always @(negedge clk_rom) begin
        check_flag({cur_name, " downloading"}, exp_dl, downloading);
        check_flag({cur_name, " ioctl_ram"}, exp_ram, ioctl_ram);
        exp_dl  = ioctl_download && ioctl_index == ioctl_pkg::IDX_ROM;
        exp_ram = ioctl_download && ioctl_index == ioctl_pkg::IDX_NVRAM;
    end

    initial begin
        rst            <= 1'b1;
        ioctl_download <= 1'b0;
        ioctl_index    <= ioctl_pkg::IDX_ROM;
        ioctl_wr       <= 1'b0;
        ioctl_addr     <= '0;
        ioctl_data     <= '0;
        rom_ready      <= 1'b0;
        model_mod   = ioctl_pkg::CORE_MOD_RESET;
        model_dipsw = ioctl_pkg::DIPSW_RESET;
        build_table();
        cycle_limit = tab_name.size() * (FIFO_DEPTH + 20) + 100;

        repeat (8) @(posedge clk_rom);
        rst <= 1'b0;
        @(negedge clk_rom);
        check_mod("after_reset", ioctl_pkg::CORE_MOD_RESET, core_mod);
        check_dipsw("after_reset", ioctl_pkg::DIPSW_RESET, dipsw);
        check_flag("after_reset rom_valid", 1'b0, rom_valid);
        check_flag("after_reset ioctl_ready", 1'b1, ioctl_ready);

        @(posedge clk_rom);
        for (int i = 0; i < tab_name.size(); i++) begin
            apply_entry(i);
            // Config writes and dropped writes are checked once settled
            if (tab_exp[i] != EXP_ROM && tab_exp[i] != EXP_NVRAM) begin
                drain_pipeline();
                check_mod(tab_name[i], model_mod, core_mod);
                check_dipsw(tab_name[i], model_dipsw, dipsw);
                @(posedge clk_rom);
            end
        end

        drain_pipeline();
        check_mod("final", model_mod, core_mod);
        check_dipsw("final", model_dipsw, dipsw);
        if (!saw_ready_low) begin
            report_failure("ioctl_ready never dropped during the long stall");
        end else if (!ioctl_ready) begin
            report_failure("ioctl_ready did not recover after the stall");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule
